/* Makefile */
# Verilator build and run for the dual-issue register file testbench

VERILATOR ?= verilator
TOP       ?= regfile_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+include
source/regfile_pkg.sv
source/regfile_write_if.sv
source/regfile_write_decode.sv
source/regfile_storage.sv
source/regfile_read_port.sv
source/dual_issue_regfile.sv
testbench/regfile_properties.sv
testbench/regfile_tb.sv

/* include/regfile_consts.svh */
// register file sizing macros, included by the package and any RTL that needs the sizes
`ifndef REGFILE_CONSTS_SVH
`define REGFILE_CONSTS_SVH

// architectural integer registers, x0 included
`define REGFILE_NUM_REGS 32

// register index width, log2 of the register count
`define REGFILE_ADDR_W 5

// data word width for RV32
`define REGFILE_XLEN 32

// read ports, two per issue slot
`define REGFILE_NUM_READ 4

// number of write ports is fixed at two by the decode logic
// and does not have a macro

// x0 index, hardwired to zero
`define REGFILE_ZERO_IDX 0

`endif

/* source/dual_issue_regfile.sv */
// top level of the two-write, four-read register file for a dual-issue RV32 core
`timescale 1ns/1ps

`include "regfile_consts.svh"

module dual_issue_regfile
    import regfile_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    // write ports, destination 0 means no write
    input  reg_addr_t   rd0_i,
    input  reg_addr_t   rd1_i,
    input  reg_data_t   rd0_value_i,
    input  reg_data_t   rd1_value_i,

    // read indices, a/b operands per issue slot
    input  reg_addr_t   ra0_i,
    input  reg_addr_t   rb0_i,
    input  reg_addr_t   ra1_i,
    input  reg_addr_t   rb1_i,

    // read values, combinational from the indices
    output reg_data_t   ra0_value_o,
    output reg_data_t   rb0_value_o,
    output reg_data_t   ra1_value_o,
    output reg_data_t   rb1_value_o
);

    // decoded write request
    regfile_write_if wr_bus ();

    // storage contents seen by all read ports
    reg_array_t regs_w;

    // read port order is ra0, rb0, ra1, rb1
    reg_addr_t  rd_addr_w [`REGFILE_NUM_READ];
    reg_data_t  rd_data_w [`REGFILE_NUM_READ];

    regfile_write_decode u_decode
    (
        .rd0_i          (rd0_i),
        .rd0_value_i    (rd0_value_i),
        .rd1_i          (rd1_i),
        .rd1_value_i    (rd1_value_i),
        .wr             (wr_bus.decode)
    );

    regfile_storage u_storage
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wr             (wr_bus.store),
        .regs_o         (regs_w)
    );

    assign rd_addr_w[0] = ra0_i;
    assign rd_addr_w[1] = rb0_i;
    assign rd_addr_w[2] = ra1_i;
    assign rd_addr_w[3] = rb1_i;

    // one selector per read port
    for (genvar p = 0; p < `REGFILE_NUM_READ; p++)
    begin : g_read
        regfile_read_port u_read
        (
            .regs_i     (regs_w),
            .addr_i     (rd_addr_w[p]),
            .data_o     (rd_data_w[p])
        );
    end

    assign ra0_value_o = rd_data_w[0];
    assign rb0_value_o = rd_data_w[1];
    assign ra1_value_o = rd_data_w[2];
    assign rb1_value_o = rd_data_w[3];

endmodule

/* source/regfile_pkg.sv */
// shared register file types, imported by the RTL and the testbench
package regfile_pkg;

`include "regfile_consts.svh"

    // register index as carried on rd/ra/rb ports
    typedef logic [`REGFILE_ADDR_W-1:0] reg_addr_t;

    // one register value
    typedef logic [`REGFILE_XLEN-1:0] reg_data_t;

    // one bit per register, bit 0 is never set
    typedef logic [`REGFILE_NUM_REGS-1:0] reg_mask_t;

    // whole register contents, entry 0 reads as zero
    typedef logic [`REGFILE_NUM_REGS-1:0][`REGFILE_XLEN-1:0] reg_array_t;

    // zero word, used for x0 and reset values
    localparam reg_data_t REG_ZERO = '0;

    // index of the hardwired zero register
    localparam reg_addr_t REG_X0 = reg_addr_t'(`REGFILE_ZERO_IDX);

endpackage

/* source/regfile_read_port.sv */
// read port: combinational word select of one register by index, x0 reads zero
`timescale 1ns/1ps

module regfile_read_port
    import regfile_pkg::*;
(
    // register contents from storage
    input  reg_array_t  regs_i,

    // source register index
    input  reg_addr_t   addr_i,

    // selected register value
    output reg_data_t   data_o
);

    always_comb
    begin
        if (addr_i == REG_X0)
        begin
            data_o = REG_ZERO;
        end
        else
        begin
            data_o = regs_i[addr_i];
        end
    end

endmodule

/* source/regfile_storage.sv */
// register storage: holds x1 to x31 and applies the decoded writes at each clock edge
`timescale 1ns/1ps

`include "regfile_consts.svh"

module regfile_storage
    import regfile_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,

    // decoded write request
    regfile_write_if.store      wr,

    // full contents for the read ports
    output reg_array_t          regs_o
);

    // x0 has no storage
    reg_data_t regs_q [1:`REGFILE_NUM_REGS-1];

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < `REGFILE_NUM_REGS; i++)
            begin
                regs_q[i] <= REG_ZERO;
            end
        end
        else
        begin
            for (int i = 1; i < `REGFILE_NUM_REGS; i++)
            begin
                if (wr.wr_en[i])
                begin
                    // select bit already encodes port 0 priority
                    if (wr.wr_sel[i])
                    begin
                        regs_q[i] <= wr.wr_data1;
                    end
                    else
                    begin
                        regs_q[i] <= wr.wr_data0;
                    end
                end
            end
        end
    end

    always_comb
    begin
        regs_o[`REGFILE_ZERO_IDX] = REG_ZERO;
        for (int i = 1; i < `REGFILE_NUM_REGS; i++)
        begin
            regs_o[i] = regs_q[i];
        end
    end

endmodule

/* source/regfile_write_decode.sv */
// write decode: turns both write ports into per-register enable and select masks
`timescale 1ns/1ps

`include "regfile_consts.svh"

module regfile_write_decode
    import regfile_pkg::*;
(
    // write port 0, higher priority
    input  reg_addr_t           rd0_i,
    input  reg_data_t           rd0_value_i,

    // write port 1
    input  reg_addr_t           rd1_i,
    input  reg_data_t           rd1_value_i,

    // decoded request towards storage
    regfile_write_if.decode     wr
);

    reg_mask_t hit0;
    reg_mask_t hit1;

    // one-hot match of each destination against every register
    always_comb
    begin
        hit0 = '0;
        hit1 = '0;
        for (int i = 0; i < `REGFILE_NUM_REGS; i++)
        begin
            if (rd0_i == reg_addr_t'(i))
            begin
                hit0[i] = 1'b1;
            end
            if (rd1_i == reg_addr_t'(i))
            begin
                hit1[i] = 1'b1;
            end
        end

        // x0 is never written
        hit0[`REGFILE_ZERO_IDX] = 1'b0;
        hit1[`REGFILE_ZERO_IDX] = 1'b0;
    end

    // either port enables the register
    assign wr.wr_en = hit0 | hit1;

    // port 1 only wins where port 0 does not also target the register
    assign wr.wr_sel = hit1 & ~hit0;

    // data passes through unchanged
    assign wr.wr_data0 = rd0_value_i;
    assign wr.wr_data1 = rd1_value_i;

endmodule

/* source/regfile_write_if.sv */
// decoded write request passed from the write decode to the register storage
`timescale 1ns/1ps

interface regfile_write_if
    import regfile_pkg::*;
();

    // registers written this cycle
    reg_mask_t wr_en;

    // per register, 1 takes the port 1 word
    reg_mask_t wr_sel;

    // write data from each port
    reg_data_t wr_data0;
    reg_data_t wr_data1;

    modport decode (
        output wr_en,
        output wr_sel,
        output wr_data0,
        output wr_data1
    );

    modport store (
        input wr_en,
        input wr_sel,
        input wr_data0,
        input wr_data1
    );

endinterface

/* testbench/regfile_properties.sv */
// concurrent checks on the register file top level, attached by the bind at the end of this file
`timescale 1ns/1ps

module regfile_properties
    import regfile_pkg::*;
(
    input logic         clk_i,
    input logic         rst_i,
    input reg_addr_t    rd0_i,
    input reg_data_t    rd0_value_i,
    input reg_addr_t    ra0_i,
    input reg_addr_t    rb0_i,
    input reg_addr_t    ra1_i,
    input reg_addr_t    rb1_i,
    input reg_data_t    ra0_value_o,
    input reg_data_t    rb0_value_o,
    input reg_data_t    ra1_value_o,
    input reg_data_t    rb1_value_o
);

    // x0 reads zero on every port
    assert property (@(posedge clk_i) disable iff (rst_i)
        (ra0_i == REG_X0) |-> (ra0_value_o == REG_ZERO))
        else $error("ra0 read of x0 is nonzero");
    assert property (@(posedge clk_i) disable iff (rst_i)
        (rb0_i == REG_X0) |-> (rb0_value_o == REG_ZERO))
        else $error("rb0 read of x0 is nonzero");
    assert property (@(posedge clk_i) disable iff (rst_i)
        (ra1_i == REG_X0) |-> (ra1_value_o == REG_ZERO))
        else $error("ra1 read of x0 is nonzero");
    assert property (@(posedge clk_i) disable iff (rst_i)
        (rb1_i == REG_X0) |-> (rb1_value_o == REG_ZERO))
        else $error("rb1 read of x0 is nonzero");

    // first cycle out of reset
    assert property (@(posedge clk_i) $fell(rst_i) |->
        (ra0_value_o == REG_ZERO && rb0_value_o == REG_ZERO &&
         ra1_value_o == REG_ZERO && rb1_value_o == REG_ZERO))
        else $error("nonzero read in the first cycle after reset");

    // port 0 write visible one cycle later
    assert property (@(posedge clk_i) disable iff (rst_i)
        (!$past(rst_i) && $past(rd0_i) != REG_X0 && ra0_i == $past(rd0_i))
        |-> (ra0_value_o == $past(rd0_value_i)))
        else $error("ra0 does not return the port 0 write");
    assert property (@(posedge clk_i) disable iff (rst_i)
        (!$past(rst_i) && $past(rd0_i) != REG_X0 && rb1_i == $past(rd0_i))
        |-> (rb1_value_o == $past(rd0_value_i)))
        else $error("rb1 does not return the port 0 write");

endmodule

bind dual_issue_regfile regfile_properties u_props
(
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rd0_i          (rd0_i),
    .rd0_value_i    (rd0_value_i),
    .ra0_i          (ra0_i),
    .rb0_i          (rb0_i),
    .ra1_i          (ra1_i),
    .rb1_i          (rb1_i),
    .ra0_value_o    (ra0_value_o),
    .rb0_value_o    (rb0_value_o),
    .ra1_value_o    (ra1_value_o),
    .rb1_value_o    (rb1_value_o)
);

/* testbench/regfile_tb.sv */
// testbench for the dual-issue register file, run as the simulation top with the properties bound
`timescale 1ns/1ps

`include "regfile_consts.svh"

module regfile_tb
    import regfile_pkg::*;
();

    localparam int DIRECTED_BUDGET = 100;
    localparam int RANDOM_CYCLES = 2000;
    // generous slack over directed plus random cycles
    localparam int TIMEOUT_CYCLES = DIRECTED_BUDGET + RANDOM_CYCLES + 900;

    logic       clk_i = 1'b0;
    logic       rst_i;
    reg_addr_t  rd0_i;
    reg_addr_t  rd1_i;
    reg_data_t  rd0_value_i;
    reg_data_t  rd1_value_i;
    reg_addr_t  ra0_i;
    reg_addr_t  rb0_i;
    reg_addr_t  ra1_i;
    reg_addr_t  rb1_i;
    reg_data_t  ra0_value_o;
    reg_data_t  rb0_value_o;
    reg_data_t  ra1_value_o;
    reg_data_t  rb1_value_o;

    reg_array_t  model;
    logic [31:0] lfsr_state = 32'h59a6;
    string       test_name = "reset";
    int          cycle_count = 0;

    dual_issue_regfile dut_i
    (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .rd0_i          (rd0_i),
        .rd1_i          (rd1_i),
        .rd0_value_i    (rd0_value_i),
        .rd1_value_i    (rd1_value_i),
        .ra0_i          (ra0_i),
        .rb0_i          (rb0_i),
        .ra1_i          (ra1_i),
        .rb1_i          (rb1_i),
        .ra0_value_o    (ra0_value_o),
        .rb0_value_o    (rb0_value_o),
        .ra1_value_o    (ra1_value_o),
        .rb1_value_o    (rb1_value_o)
    );

    always #2 clk_i = ~clk_i;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // expected value on any read port for a given index
    function automatic reg_data_t expected_read(reg_addr_t idx);
        if (idx == REG_X0)
        begin
            return REG_ZERO;
        end
        return model[idx];
    endfunction

    task automatic compare_data(input string test, input string port,
                                input reg_data_t exp, input reg_data_t act);
        if (act !== exp)
        begin
            $display("FAIL %s %s expected %08h actual %08h", test, port, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "read value mismatch");
        end
    endtask

    task automatic drive_cycle(input string name,
                               input reg_addr_t w0, input reg_data_t d0,
                               input reg_addr_t w1, input reg_data_t d1,
                               input reg_addr_t a0, input reg_addr_t b0,
                               input reg_addr_t a1, input reg_addr_t b1);
        @(posedge clk_i);
        test_name = name;
        rd0_i <= w0;
        rd0_value_i <= d0;
        rd1_i <= w1;
        rd1_value_i <= d1;
        ra0_i <= a0;
        rb0_i <= b0;
        ra1_i <= a1;
        rb1_i <= b1;
    endtask

    // outputs settle mid-cycle, then the pending writes go into the model
    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            model = '0;
        end
        else
        begin
            compare_data(test_name, "ra0", expected_read(ra0_i), ra0_value_o);
            compare_data(test_name, "rb0", expected_read(rb0_i), rb0_value_o);
            compare_data(test_name, "ra1", expected_read(ra1_i), ra1_value_o);
            compare_data(test_name, "rb1", expected_read(rb1_i), rb1_value_o);
            // port 0 applied last so it wins a shared destination
            if (rd1_i != REG_X0)
            begin
                model[rd1_i] = rd1_value_i;
            end
            if (rd0_i != REG_X0)
            begin
                model[rd0_i] = rd0_value_i;
            end
        end
    end

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        reg_addr_t w0;
        reg_addr_t w1;
        rst_i <= 1'b1;
        rd0_i <= '0;
        rd1_i <= '0;
        rd0_value_i <= '0;
        rd1_value_i <= '0;
        // nonzero indices across reset release
        ra0_i <= 5'd1;
        rb0_i <= 5'd2;
        ra1_i <= 5'd30;
        rb1_i <= 5'd31;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int i = 0; i < `REGFILE_NUM_REGS; i++)
        begin
            drive_cycle("reset_zero", REG_X0, '0, REG_X0, '0, reg_addr_t'(i),
                        reg_addr_t'(31 - i), reg_addr_t'(i), reg_addr_t'(31 - i));
        end

        drive_cycle("write_port0", 5'd3, 32'hdead_beef, REG_X0, '0, 5'd0, 5'd0, 5'd0, 5'd0);
        drive_cycle("write_port0", REG_X0, '0, REG_X0, '0, 5'd3, 5'd3, 5'd3, 5'd3);
        drive_cycle("write_port1", REG_X0, '0, 5'd7, 32'hcafe_f00d, 5'd3, 5'd0, 5'd0, 5'd3);
        drive_cycle("write_port1", REG_X0, '0, REG_X0, '0, 5'd7, 5'd7, 5'd7, 5'd7);

        drive_cycle("x0_write", REG_X0, 32'hffff_ffff, REG_X0, 32'h1234_5678,
                    5'd0, 5'd0, 5'd0, 5'd0);
        drive_cycle("x0_write", REG_X0, '0, REG_X0, '0, 5'd0, 5'd0, 5'd0, 5'd0);

        drive_cycle("same_dest", 5'd9, 32'h1111_1111, 5'd9, 32'h2222_2222,
                    5'd9, 5'd9, 5'd9, 5'd9);
        drive_cycle("same_dest", REG_X0, '0, REG_X0, '0, 5'd9, 5'd9, 5'd9, 5'd9);

        // old value while the write is pending, new value after the edge
        drive_cycle("read_during_write", 5'd9, 32'h3333_3333, 5'd31, 32'h4444_4444,
                    5'd9, 5'd31, 5'd9, 5'd31);
        drive_cycle("read_during_write", REG_X0, '0, REG_X0, '0, 5'd9, 5'd31, 5'd9, 5'd31);

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            w0 = reg_addr_t'(take_bits(5));
            // about one cycle in four shares the destination
            if (take_bits(2) == 0)
            begin
                w1 = w0;
            end
            else
            begin
                w1 = reg_addr_t'(take_bits(5));
            end
            drive_cycle("random", w0, take_bits(32), w1, take_bits(32),
                        reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5)),
                        reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5)));
        end

        drive_cycle("drain", REG_X0, '0, REG_X0, '0, 5'd0, 5'd0, 5'd0, 5'd0);
        @(negedge clk_i);
        @(posedge clk_i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
